// File: list.f
core_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
exec_unit.sv
mem_unit.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - core_pkg.sv
  - fetch_unit.sv
  - decode_unit.sv
  - reg_file.sv
  - exec_unit.sv
  - mem_unit.sv
  - rv_core.sv
  - target: simulation
    files:
      - rv_core_asserts.sv
      - tb_rv_core.sv

// File: tb_rv_core.sv
/* rv_core testbench */
`timescale 1ns/10ps
module tb_rv_core;
    import core_pkg::*;

    localparam word_t RESET_PC    = 32'h0000_0000;
    localparam int    PROG_LEN    = 54;
    localparam word_t END_PC      = PROG_LEN * 4;
    localparam int    CYCLE_LIMIT = PROG_LEN * 12 + 50;

    typedef struct packed {
        retire_t   ret;
        word_t     npc;
        logic      is_mem;
        dmem_req_t mem;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        imem_req, imem_valid, dmem_req, dmem_valid, retire_valid;
    word_t       imem_addr, imem_rdata, dmem_rdata;
    dmem_req_t   dmem_out, d_req;
    retire_t     retire_info;
    word_t       xreg [32];     // model registers
    word_t       ref_mem [64];  // model data memory
    word_t       dmem [64];     // memory seen by the DUT
    word_t       model_pc = RESET_PC;
    word_t       exp_fetch = RESET_PC;
    word_t       i_addr;
    expect_t     ret_exp, mem_exp;
    int          i_wait = 0, d_wait = 0;
    int          checks = 0, errors = 0, cycles = 0, retired = 0;
    logic        last_fetch = 1'b0;
    logic [15:0] lfsr = 16'd25;

    // ALU ops, x0 write, upper imm, sw/lw, six branches both ways, jal, jalr, ecall
    word_t prog [PROG_LEN] = '{
        32'h123450B7, 32'hFF900113, 32'h00C00193, 32'h00310233,
        32'h403102B3, 32'h00309333, 32'h003123B3, 32'h00313433,
        32'h0020C4B3, 32'h00315533, 32'h403155B3, 32'h00116633,
        32'h0020F6B3, 32'hFFF12713, 32'h00513793, 32'h7FF0C813,
        32'h0F016893, 32'hFF00F913, 32'h00419993, 32'h00815A13,
        32'h40215A93, 32'h06318013, 32'h00300B33, 32'h00001B97,
        32'h0041A823, 32'hFE11AE23, 32'h0101AC03, 32'h00802C83,
        32'h02802D03, 32'h00310463, 32'h00311463, 32'h00100F93,
        32'h00319463, 32'h00318463, 32'h00100F93, 32'h00315463,
        32'h00314463, 32'h00100F93, 32'h0021C463, 32'h0021D463,
        32'h00100F93, 32'h00316463, 32'h00317463, 32'h00100F93,
        32'h0021F463, 32'h0021E463, 32'h00100F93, 32'h00800DEF,
        32'h00100F93, 32'h00000E17, 32'h00DE0EE7, 32'h00100F93,
        32'h00000073, 32'h019C0F33
    };

    rv_core dut_i (
        .clk(clk), .reset(reset),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_out(dmem_out),
        .dmem_valid(dmem_valid), .dmem_rdata(dmem_rdata),
        .retire_valid(retire_valid), .retire_info(retire_info)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic random_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 16'hB400;  // galois taps
        return b;
    endfunction

    function automatic int random_delay();
        logic hi, lo;
        hi = random_bit();
        lo = random_bit();
        return {hi, lo} + 1;  // 1 to 4 cycles
    endfunction

    function automatic word_t fetch_word(word_t addr);
        if (addr[31:2] < PROG_LEN) return prog[addr[31:2]];
        return 32'h0000_0013;  // nop past the end
    endfunction

    // one reference step that leaves the model state untouched
    function automatic expect_t model_step(word_t pc);
        expect_t e;
        word_t   ins, a, b, res;
        word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
        logic    take;
        ins   = fetch_word(pc);
        a     = xreg[ins[19:15]];
        b     = xreg[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e = '0;
        e.ret.pc = pc;
        e.ret.rd = ins[11:7];
        e.npc    = pc + 4;
        case (ins[6:0])
            OPC_OP, OPC_OP_IMM: begin
                if (ins[6:0] == OPC_OP_IMM) b = imm_i;
                case (ins[14:12])
                    3'd0: res = (ins[5] && ins[30]) ? a - b : a + b;  // sub only in reg form
                    3'd1: res = a << b[4:0];
                    3'd2: res = {31'b0, $signed(a) < $signed(b)};
                    3'd3: res = {31'b0, a < b};
                    3'd4: res = a ^ b;
                    3'd5: begin
                        if (ins[30]) res = $signed(a) >>> b[4:0];
                        else res = a >> b[4:0];
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
                e.ret.wdata = res;
                e.ret.we    = 1'b1;
            end
            OPC_LOAD: begin
                e.is_mem      = 1'b1;
                e.mem.addr    = a + imm_i;
                e.ret.wdata   = ref_mem[e.mem.addr[7:2]];
                e.ret.we      = 1'b1;
            end
            OPC_STORE: begin
                e.is_mem = 1'b1;
                e.mem    = '{addr: a + imm_s, wdata: b, write: 1'b1};
            end
            OPC_BRANCH: begin
                case (ins[14:12])
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) e.npc = pc + imm_b;
            end
            OPC_LUI, OPC_AUIPC: begin
                e.ret.wdata = (ins[6:0] == OPC_LUI) ? imm_u : pc + imm_u;
                e.ret.we    = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                e.ret.wdata = pc + 4;
                e.ret.we    = 1'b1;
                e.npc = (ins[6:0] == OPC_JAL) ? pc + imm_j : (a + imm_i) & ~32'd1;
            end
            default: ;  // system words retire without a write
        endcase
        e.ret.we = e.ret.we && (e.ret.rd != 5'd0);
        return e;
    endfunction

    // instruction and data memory models with random latency
    always @(posedge clk) begin
        imem_valid <= 1'b0;
        dmem_valid <= 1'b0;
        if (!reset && imem_req) begin
            check_value("imem_addr", imem_addr, exp_fetch);
            if (model_pc == END_PC) last_fetch = 1'b1;
            i_addr = imem_addr;
            i_wait = random_delay();
        end
        if (!reset && dmem_req) begin
            mem_exp = model_step(model_pc);
            if (!mem_exp.is_mem) begin
                errors++;
                $display("Data request at %0t for an instruction without memory access", $time);
            end
            check_value("dmem_out.addr", dmem_out.addr, mem_exp.mem.addr);
            check_value("dmem_out.write", dmem_out.write, mem_exp.mem.write);
            if (mem_exp.mem.write) check_value("dmem_out.wdata", dmem_out.wdata, mem_exp.mem.wdata);
            d_req  = dmem_out;
            d_wait = random_delay();
        end
        if (i_wait != 0) begin
            i_wait--;
            if (i_wait == 0) begin
                imem_valid <= 1'b1;
                imem_rdata <= fetch_word(i_addr);
            end
        end
        if (d_wait != 0) begin
            d_wait--;
            if (d_wait == 0) begin
                dmem_valid <= 1'b1;
                dmem_rdata <= dmem[d_req.addr[7:2]];
                if (d_req.write) dmem[d_req.addr[7:2]] = d_req.wdata;
            end
        end
    end

    // compare each retire with the model, then advance the model
    always @(posedge clk) begin
        if (!reset && retire_valid) begin
            ret_exp = model_step(model_pc);
            check_value("retire_info.pc", retire_info.pc, ret_exp.ret.pc);
            check_value("retire_info.rd", retire_info.rd, ret_exp.ret.rd);
            check_value("retire_info.we", retire_info.we, ret_exp.ret.we);
            if (ret_exp.ret.we) begin
                check_value("retire_info.wdata", retire_info.wdata, ret_exp.ret.wdata);
                xreg[ret_exp.ret.rd] = ret_exp.ret.wdata;
            end
            if (ret_exp.is_mem && ret_exp.mem.write) begin
                ref_mem[ret_exp.mem.addr[7:2]] = ret_exp.mem.wdata;
            end
            model_pc  = ret_exp.npc;
            exp_fetch = ret_exp.npc;  // checked on the next imem_req
            retired++;
        end
    end

    always @(posedge clk) begin
        cycles++;
    end

    initial begin
        wait (cycles > CYCLE_LIMIT);
        $display("Timeout: program not finished after %0d cycles", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_rdata = '0;
        dmem_valid = 1'b0;
        dmem_rdata = '0;
        xreg       = '{default: '0};
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = 32'hd0d0_0000 | (i << 2);  // address in every word
            ref_mem[i] = dmem[i];
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (last_fetch);
        $display("retired %0d, checks %0d, errors %0d, assertion failures %0d",
                 retired, checks, errors, dut_i.asserts_i.failures);
        if (errors == 0 && dut_i.asserts_i.failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: rv_core_asserts.sv
/* strobe protocol checks */
`timescale 1ns/10ps
module rv_core_asserts (
    input logic clk,
    input logic reset,
    input logic imem_req,
    input logic dmem_req,
    input logic retire_valid
);

    int failures = 0;  // failed assertions so far

    imem_req_pulse: assert property (@(posedge clk) disable iff (reset) imem_req |=> !imem_req)
        else begin
            $error("imem_req high for two cycles in a row");
            failures++;
        end

    dmem_req_pulse: assert property (@(posedge clk) disable iff (reset) dmem_req |=> !dmem_req)
        else begin
            $error("dmem_req high for two cycles in a row");
            failures++;
        end

    retire_pulse: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> !retire_valid)
        else begin
            $error("retire_valid repeated on consecutive cycles");
            failures++;
        end

    // strobes quiet once reset has been seen
    reset_quiet: assert property (@(posedge clk)
        reset |=> !(imem_req || dmem_req || retire_valid))
        else begin
            $error("strobe high during reset");
            failures++;
        end

endmodule

bind rv_core rv_core_asserts asserts_i (
    .clk(clk), .reset(reset),
    .imem_req(imem_req), .dmem_req(dmem_req),
    .retire_valid(retire_valid)
);

// File: rv_core.sv
/* multi-cycle rv32i core */
`timescale 1ns/10ps
module rv_core #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                reset,
    output logic                imem_req,
    output core_pkg::word_t     imem_addr,
    input  logic                imem_valid,
    input  core_pkg::word_t     imem_rdata,
    output logic                dmem_req,
    output core_pkg::dmem_req_t dmem_out,
    input  logic                dmem_valid,
    input  core_pkg::word_t     dmem_rdata,
    output logic                retire_valid,
    output core_pkg::retire_t   retire_info
);
    import core_pkg::*;

    word_t   pc, inst, next_pc, exec_result;
    word_t   rs1_data, rs2_data;
    logic    inst_valid;
    decode_t dec;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .retire_valid(retire_valid), .next_pc(next_pc),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .pc(pc), .inst(inst), .inst_valid(inst_valid)
    );

    decode_unit u_decode (.inst(inst), .dec(dec));

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .rs1(dec.rs1), .rs2(dec.rs2),
        .retire_valid(retire_valid), .retire_info(retire_info),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    exec_unit u_exec (
        .dec(dec), .pc(pc),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .exec_result(exec_result), .next_pc(next_pc)
    );

    // data side and retire
    mem_unit u_mem (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .pc(pc), .dec(dec),
        .exec_result(exec_result), .rs2_data(rs2_data),
        .dmem_valid(dmem_valid), .dmem_rdata(dmem_rdata),
        .dmem_req(dmem_req), .dmem_out(dmem_out),
        .retire_valid(retire_valid), .retire_info(retire_info)
    );

endmodule

// File: mem_unit.sv
/* data memory access and writeback */
`timescale 1ns/10ps
module mem_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  core_pkg::word_t     pc,
    input  core_pkg::decode_t   dec,
    input  core_pkg::word_t     exec_result,
    input  core_pkg::word_t     rs2_data,
    input  logic                dmem_valid,
    input  core_pkg::word_t     dmem_rdata,
    output logic                dmem_req,
    output core_pkg::dmem_req_t dmem_out,
    output logic                retire_valid,
    output core_pkg::retire_t   retire_info
);
    import core_pkg::*;

    mem_state_t state;
    logic       is_load, is_mem;
    logic       writes;  // class writes rd

    assign is_load = (dec.iclass == LOAD);
    assign is_mem  = is_load || (dec.iclass == STORE);

    always_comb begin
        case (dec.iclass)
            ALU_REG, ALU_IMM, LOAD, LUI, AUIPC, JAL, JALR: writes = 1'b1;
            default: writes = 1'b0;
        endcase
    end

    // first execute cycle either issues the access or retires directly
    assign dmem_req     = inst_valid && (state == MEM_IDLE) && is_mem;
    assign retire_valid = (inst_valid && (state == MEM_IDLE) && !is_mem) ||
                          ((state == MEM_WAIT) && dmem_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MEM_IDLE;
        end else begin
            case (state)
                MEM_IDLE: if (dmem_req) state <= MEM_WAIT;
                MEM_WAIT: if (dmem_valid) state <= MEM_IDLE;
                default:  state <= MEM_IDLE;
            endcase
        end
    end

    assign dmem_out = '{addr: exec_result, wdata: rs2_data, write: !is_load};

    assign retire_info = '{
        pc:    pc,
        wdata: is_load ? dmem_rdata : exec_result,
        rd:    dec.rd,
        we:    writes && (dec.rd != '0)
    };

endmodule

// File: exec_unit.sv
/* execute unit with ALU */
`timescale 1ns/10ps
module exec_unit (
    input  core_pkg::decode_t dec,
    input  core_pkg::word_t   pc,
    input  core_pkg::word_t   rs1_data,
    input  core_pkg::word_t   rs2_data,
    output core_pkg::word_t   exec_result,
    output core_pkg::word_t   next_pc
);
    import core_pkg::*;

    word_t      alu_a, alu_b, alu_y;
    word_t      link;  // pc+4
    logic [4:0] shamt;
    logic       taken;

    assign link  = pc + 32'd4;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.iclass)
            ALU_IMM, LOAD, STORE, JALR: begin
                alu_a = rs1_data;
                alu_b = dec.imm;
            end
            AUIPC, JAL, BRANCH: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            LUI: begin
                alu_a = '0;
                alu_b = dec.imm;
            end
            default: begin  // ALU_REG
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_y = alu_a - alu_b;
            ALU_SLL:  alu_y = alu_a << shamt;
            ALU_SLT:  alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_y = {31'b0, alu_a < alu_b};
            ALU_XOR:  alu_y = alu_a ^ alu_b;
            ALU_SRL:  alu_y = alu_a >> shamt;
            ALU_SRA:  alu_y = $signed(alu_a) >>> shamt;
            ALU_OR:   alu_y = alu_a | alu_b;
            ALU_AND:  alu_y = alu_a & alu_b;
            default:  alu_y = alu_a + alu_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.iclass)
            BRANCH:  next_pc = taken ? alu_y : link;
            JAL:     next_pc = alu_y;
            JALR:    next_pc = {alu_y[31:1], 1'b0};
            default: next_pc = link;
        endcase
    end

    assign exec_result = (dec.iclass == JAL || dec.iclass == JALR) ? link : alu_y;

endmodule

// File: reg_file.sv
/* integer register file */
`timescale 1ns/10ps
module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  logic                retire_valid,
    input  core_pkg::retire_t   retire_info,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_valid && retire_info.we) begin
            regs[retire_info.rd] <= retire_info.wdata;  // we is never set for x0
        end
    end

    // x0 hardwired to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: decode_unit.sv
/* instruction decoder */
`timescale 1ns/10ps
module decode_unit (
    input  core_pkg::word_t   inst,
    output core_pkg::decode_t dec
);
    import core_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alt;  // funct7 bit 5
    inst_class_t iclass;
    alu_op_t     alu_op;
    word_t       imm;
    word_t       imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    // sign-extended immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_OP:     iclass = ALU_REG;
            OPC_OP_IMM: iclass = ALU_IMM;
            OPC_LOAD:   iclass = LOAD;
            OPC_STORE:  iclass = STORE;
            OPC_BRANCH: iclass = BRANCH;
            OPC_LUI:    iclass = LUI;
            OPC_AUIPC:  iclass = AUIPC;
            OPC_JAL:    iclass = JAL;
            OPC_JALR:   iclass = JALR;
            default:    iclass = UNSUPPORTED;  // SYSTEM lands here too
        endcase
    end

    always_comb begin
        case (iclass)
            ALU_IMM, LOAD, JALR: imm = imm_i;
            STORE:               imm = imm_s;
            BRANCH:              imm = imm_b;
            LUI, AUIPC:          imm = imm_u;
            JAL:                 imm = imm_j;
            default:             imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;  // addresses and targets are sums
        if (iclass == ALU_REG || iclass == ALU_IMM) begin
            case (funct3)
                3'b000:  alu_op = (iclass == ALU_REG && alt) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;  // SRAI shares the bit
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    assign dec = '{
        iclass: iclass,
        alu_op: alu_op,
        rd:     inst[11:7],
        rs1:    inst[19:15],
        rs2:    inst[24:20],
        funct3: funct3,
        imm:    imm
    };

endmodule

// File: fetch_unit.sv
/* instruction fetch */
`timescale 1ns/10ps
module fetch_unit #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_valid,
    input  core_pkg::word_t imem_rdata,
    input  logic            retire_valid,
    input  core_pkg::word_t next_pc,
    output logic            imem_req,
    output core_pkg::word_t imem_addr,
    output core_pkg::word_t pc,
    output core_pkg::word_t inst,
    output logic            inst_valid
);
    import core_pkg::*;

    fetch_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH_REQ;
            pc       <= RESET_PC;
            imem_req <= 1'b0;
        end else begin
            imem_req <= 1'b0;  // one cycle only
            case (state)
                FETCH_REQ: begin
                    imem_req <= 1'b1;  // first fetch out of reset
                    state    <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (imem_valid) state <= EXECUTE;
                end
                EXECUTE: begin
                    // retire moves pc and launches the next fetch at once
                    if (retire_valid) begin
                        pc       <= next_pc;
                        imem_req <= 1'b1;
                        state    <= FETCH_WAIT;
                    end
                end
                default: state <= FETCH_REQ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && imem_valid) begin
            inst <= imem_rdata;  // held for the whole instruction
        end
    end

    assign imem_addr  = pc;  // stable until imem_valid
    assign inst_valid = (state == EXECUTE);

endmodule

// File: core_pkg.sv
/* rv32i core shared types */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes of the kept instructions
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_REG, ALU_IMM, LOAD, STORE, BRANCH,
        LUI, AUIPC, JAL, JALR, UNSUPPORTED
    } inst_class_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef struct packed {
        inst_class_t iclass;
        alu_op_t     alu_op;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  funct3;  // branch condition
        word_t       imm;
    } decode_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } dmem_req_t;

    typedef struct packed {
        word_t     pc;
        word_t     wdata;
        reg_addr_t rd;
        logic      we;
    } retire_t;

    typedef enum logic [1:0] {FETCH_REQ, FETCH_WAIT, EXECUTE} fetch_state_t;
    typedef enum logic {MEM_IDLE, MEM_WAIT} mem_state_t;

endpackage
